// ==== all.f ====
+incdir+tests
hw/mem_pkg.sv
hw/stage_reg.sv
hw/data_memory.sv
hw/stack_pointer.sv
hw/memory_stage.sv
hw/mem_stage_top.sv
tests/tb_mem_stage.sv

// ==== hw/data_memory.sv ====
`timescale 1ns/1ns

module data_memory (
  input  logic                        clk,
  input  logic                        write,
  input  logic [mem_pkg::ADDR_W-1:0]  write_address,
  input  logic [mem_pkg::DATA_W-1:0]  write_data,
  input  logic [mem_pkg::ADDR_W-1:0]  read_address,
  output logic [mem_pkg::DATA_W-1:0]  read_data
);

  import mem_pkg::*;

  logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];  // 1024 words

  always_ff @(posedge clk)
  begin
    if (write)
    begin
      mem[write_address] <= write_data;
    end
  end

  // reads see the stored word, not a same-cycle write
  assign read_data = mem[read_address];

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

  localparam int ADDR_W  = 10;  // data memory address width
  localparam int DATA_W  = 16;  // memory word width
  localparam int PC_W    = 32;
  localparam int FLAGS_W = 3;
  localparam int REG_W   = 3;   // write-back register index

  localparam logic [ADDR_W-1:0] STACK_TOP  = ADDR_W'(1023);  // sp after reset
  localparam logic [PC_W-1:0]   INT_VECTOR = '0;              // interrupt entry

  // effective address for plain loads and stores
  typedef enum logic {
    ADDR_STD = 1'b0,  // store-address operand
    ADDR_LDD = 1'b1   // load-address operand
  } mem_addr_sel_t;

  typedef enum logic [1:0] {
    WSRC_FLAGS = 2'b00,  // flags, zero-extended
    WSRC_PC_HI = 2'b01,
    WSRC_PC_LO = 2'b10,
    WSRC_REG   = 2'b11
  } mem_wsrc_t;

  // one operation as handed over by execute
  typedef struct packed {
    logic                read;
    logic                write;
    logic                push;
    logic                pop;
    mem_addr_sel_t       addr_sel;
    mem_wsrc_t           wsrc;
    logic [DATA_W-1:0]   std_address;
    logic [DATA_W-1:0]   ldd_address;
    logic [DATA_W-1:0]   reg_data;
    logic [FLAGS_W-1:0]  flags;
    logic [PC_W-1:0]     pc;
    logic [PC_W-1:0]     pc_from_ex;
    logic                pc_from_memory;
    logic                interrupt;
    logic                wb_enable;
    logic [REG_W-1:0]    wb_reg;
  } ex_mem_t;

  typedef struct packed {
    logic [DATA_W-1:0]   read_data;
    logic [PC_W-1:0]     final_pc;
    logic                wb_enable;
    logic [REG_W-1:0]    wb_reg;
  } mem_wb_t;

endpackage

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/1ns

module mem_stage_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic                          read,
  input  logic                          write,
  input  logic                          push,
  input  logic                          pop,
  input  mem_pkg::mem_addr_sel_t        addr_sel,
  input  mem_pkg::mem_wsrc_t            wsrc,
  input  logic [mem_pkg::DATA_W-1:0]    std_address,
  input  logic [mem_pkg::DATA_W-1:0]    ldd_address,
  input  logic [mem_pkg::DATA_W-1:0]    reg_data,
  input  logic [mem_pkg::FLAGS_W-1:0]   flags,
  input  logic [mem_pkg::PC_W-1:0]      pc,
  input  logic [mem_pkg::PC_W-1:0]      pc_from_ex,
  input  logic                          pc_from_memory,
  input  logic                          interrupt,
  input  logic                          ex_wb_enable,
  input  logic [mem_pkg::REG_W-1:0]     ex_wb_reg,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [mem_pkg::DATA_W-1:0]    read_data,
  output logic [mem_pkg::PC_W-1:0]      final_pc,
  output logic                          wb_enable,
  output logic [mem_pkg::REG_W-1:0]     wb_reg
);

  import mem_pkg::*;

  ex_mem_t           ex_in;
  ex_mem_t           ex_q;
  mem_wb_t           wb_in;
  mem_wb_t           wb_q;
  logic              ex_valid;
  logic              wb_in_ready;
  logic              fire;  // operation moves into u_mem_wb
  logic [DATA_W-1:0] stage_read_data;
  logic [PC_W-1:0]   stage_final_pc;

  assign ex_in = '{
    read:           read,
    write:          write,
    push:           push,
    pop:            pop,
    addr_sel:       addr_sel,
    wsrc:           wsrc,
    std_address:    std_address,
    ldd_address:    ldd_address,
    reg_data:       reg_data,
    flags:          flags,
    pc:             pc,
    pc_from_ex:     pc_from_ex,
    pc_from_memory: pc_from_memory,
    interrupt:      interrupt,
    wb_enable:      ex_wb_enable,
    wb_reg:         ex_wb_reg
  };

  stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (ex_in),
    .out_ready (wb_in_ready),
    .in_ready  (in_ready),
    .out_valid (ex_valid),
    .out_data  (ex_q)
  );

  assign fire = ex_valid && wb_in_ready;

  memory_stage u_memory_stage (
    .clk            (clk),
    .reset          (reset),
    .fire           (fire),
    .read           (ex_q.read),
    .write          (ex_q.write),
    .push           (ex_q.push),
    .pop            (ex_q.pop),
    .addr_sel       (ex_q.addr_sel),
    .wsrc           (ex_q.wsrc),
    .std_address    (ex_q.std_address),
    .ldd_address    (ex_q.ldd_address),
    .reg_data       (ex_q.reg_data),
    .flags          (ex_q.flags),
    .pc             (ex_q.pc),
    .pc_from_ex     (ex_q.pc_from_ex),
    .pc_from_memory (ex_q.pc_from_memory),
    .interrupt      (ex_q.interrupt),
    .read_data      (stage_read_data),
    .final_pc       (stage_final_pc)
  );

  assign wb_in = '{
    read_data: stage_read_data,
    final_pc:  stage_final_pc,
    wb_enable: ex_q.wb_enable,
    wb_reg:    ex_q.wb_reg
  };

  stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (ex_valid),
    .in_data   (wb_in),
    .out_ready (out_ready),
    .in_ready  (wb_in_ready),
    .out_valid (out_valid),
    .out_data  (wb_q)
  );

  assign read_data = wb_q.read_data;
  assign final_pc  = wb_q.final_pc;
  assign wb_enable = wb_q.wb_enable;
  assign wb_reg    = wb_q.wb_reg;

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          fire,
  input  logic                          read,
  input  logic                          write,
  input  logic                          push,
  input  logic                          pop,
  input  mem_pkg::mem_addr_sel_t        addr_sel,
  input  mem_pkg::mem_wsrc_t            wsrc,
  input  logic [mem_pkg::DATA_W-1:0]    std_address,
  input  logic [mem_pkg::DATA_W-1:0]    ldd_address,
  input  logic [mem_pkg::DATA_W-1:0]    reg_data,
  input  logic [mem_pkg::FLAGS_W-1:0]   flags,
  input  logic [mem_pkg::PC_W-1:0]      pc,
  input  logic [mem_pkg::PC_W-1:0]      pc_from_ex,
  input  logic                          pc_from_memory,
  input  logic                          interrupt,
  output logic [mem_pkg::DATA_W-1:0]    read_data,
  output logic [mem_pkg::PC_W-1:0]      final_pc
);

  import mem_pkg::*;

  logic [ADDR_W-1:0] push_address;
  logic [ADDR_W-1:0] pop_address;
  logic [ADDR_W-1:0] eff_address;
  logic [DATA_W-1:0] write_data;
  logic [DATA_W-1:0] mem_word;
  logic [PC_W-1:0]   ret_q;  // last two words read
  logic              do_read;
  logic              do_write;

  // a pop is a read, a push is a write
  assign do_read  = read || pop;
  assign do_write = write || push;

  always_comb
  begin
    if (pop)
    begin
      eff_address = pop_address;
    end
    else if (push)
    begin
      eff_address = push_address;
    end
    else if (addr_sel == ADDR_LDD)
    begin
      eff_address = ldd_address[ADDR_W-1:0];
    end
    else
    begin
      eff_address = std_address[ADDR_W-1:0];
    end
  end

  always_comb
  begin
    case (wsrc)
      WSRC_FLAGS: write_data = {{(DATA_W-FLAGS_W){1'b0}}, flags};
      WSRC_PC_HI: write_data = pc[PC_W-1:DATA_W];
      WSRC_PC_LO: write_data = pc[DATA_W-1:0];
      default:    write_data = reg_data;  // WSRC_REG
    endcase
  end

  stack_pointer u_stack_pointer (
    .clk          (clk),
    .reset        (reset),
    .push         (fire && push),
    .pop          (fire && pop),
    .push_address (push_address),
    .pop_address  (pop_address)
  );

  data_memory u_data_memory (
    .clk           (clk),
    .write         (fire && do_write),
    .write_address (eff_address),
    .write_data    (write_data),
    .read_address  (eff_address),
    .read_data     (mem_word)
  );

  assign read_data = do_read ? mem_word : '0;

  // new word enters the top, old top drops to the bottom half
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ret_q <= '0;
    end
    else if (fire && do_read)
    begin
      ret_q <= {mem_word, ret_q[PC_W-1:DATA_W]};
    end
  end

  // pops of lower then upper leave the whole return pc in ret_q
  always_comb
  begin
    if (interrupt)
    begin
      final_pc = INT_VECTOR;
    end
    else if (pc_from_memory)
    begin
      final_pc = ret_q;  // value before this operation
    end
    else
    begin
      final_pc = pc_from_ex;
    end
  end

endmodule

// ==== hw/stack_pointer.sv ====
`timescale 1ns/1ns

module stack_pointer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        push,
  input  logic                        pop,
  output logic [mem_pkg::ADDR_W-1:0]  push_address,
  output logic [mem_pkg::ADDR_W-1:0]  pop_address
);

  import mem_pkg::*;

  logic [ADDR_W-1:0] sp;  // next free slot

  assign push_address = sp;
  assign pop_address  = sp + 1'b1;  // last pushed word, wraps

  // the stack grows downward and wraps modulo the memory size
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sp <= STACK_TOP;
    end
    else if (push)
    begin
      sp <= sp - 1'b1;
    end
    else if (pop)
    begin
      sp <= sp + 1'b1;
    end
  end

endmodule

// ==== hw/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  input  logic     out_ready,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data
);

  // empty, or the held entry leaves on this edge
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else if (in_ready)
    begin
      out_valid <= in_valid;  // refill or go empty
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      out_data <= in_data;
    end
  end

endmodule

// ==== tests/mem_ref_model.svh ====
// model state, advanced once per accepted operation
logic [DATA_W-1:0] ref_mem [0:(2**ADDR_W)-1];
logic [ADDR_W-1:0] ref_sp;
logic [PC_W-1:0]   ref_ret;

function automatic void reset_model();
  ref_sp  = STACK_TOP;  // memory keeps its contents
  ref_ret = '0;
endfunction

function automatic logic [DATA_W-1:0] ref_write_data(input ex_mem_t op);
  case (op.wsrc)
    WSRC_FLAGS: return DATA_W'(op.flags);
    WSRC_PC_HI: return op.pc[PC_W-1:DATA_W];
    WSRC_PC_LO: return op.pc[DATA_W-1:0];
    default:    return op.reg_data;
  endcase
endfunction

// expected write-back result of one operation
function automatic mem_wb_t ref_step(input ex_mem_t op);
  mem_wb_t           res;
  logic [ADDR_W-1:0] addr;
  res = '{read_data: '0, final_pc: op.pc_from_ex, wb_enable: op.wb_enable, wb_reg: op.wb_reg};
  if (op.interrupt)
    res.final_pc = INT_VECTOR;
  else if (op.pc_from_memory)
    res.final_pc = ref_ret;  // return pc from before this op
  addr = (op.addr_sel == ADDR_LDD) ? op.ldd_address[ADDR_W-1:0] : op.std_address[ADDR_W-1:0];
  if (op.pop)
  begin
    ref_sp = ref_sp + 1'b1;
    addr   = ref_sp;
  end
  else if (op.push)
  begin
    addr   = ref_sp;
    ref_sp = ref_sp - 1'b1;
  end
  if (op.read || op.pop)
  begin
    res.read_data = ref_mem[addr];
    ref_ret       = {res.read_data, ref_ret[PC_W-1:DATA_W]};
  end
  if (op.write || op.push)
    ref_mem[addr] = ref_write_data(op);
  return res;
endfunction

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage;

  import mem_pkg::*;

  localparam int RANDOM_OPS  = 200;
  localparam int TOTAL_OPS   = 16 + 9 + 5 + 8 + 16 + RANDOM_OPS + 2;  // all tests together
  localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 200;

  logic              clk;
  logic              reset;
  logic              in_valid;
  logic              in_ready;
  ex_mem_t           op_in;  // fields go out on the loose ports
  logic              out_valid;
  logic              out_ready;
  logic [DATA_W-1:0] read_data;
  logic [PC_W-1:0]   final_pc;
  logic              wb_enable;
  logic [REG_W-1:0]  wb_reg;
  logic              stall_mode;
  mem_wb_t           expected [$];
  mem_wb_t           exp_res;
  int                cycles;
  int                checks;
  int                errors;
  int                errors_at_start;
  int                tests_run;
  int                tests_failed;

  `include "mem_ref_model.svh"

  mem_stage_top uut (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .read           (op_in.read),
    .write          (op_in.write),
    .push           (op_in.push),
    .pop            (op_in.pop),
    .addr_sel       (op_in.addr_sel),
    .wsrc           (op_in.wsrc),
    .std_address    (op_in.std_address),
    .ldd_address    (op_in.ldd_address),
    .reg_data       (op_in.reg_data),
    .flags          (op_in.flags),
    .pc             (op_in.pc),
    .pc_from_ex     (op_in.pc_from_ex),
    .pc_from_memory (op_in.pc_from_memory),
    .interrupt      (op_in.interrupt),
    .ex_wb_enable   (op_in.wb_enable),
    .ex_wb_reg      (op_in.wb_reg),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .read_data      (read_data),
    .final_pc       (final_pc),
    .wb_enable      (wb_enable),
    .wb_reg         (wb_reg)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    #1;
    out_ready = stall_mode ? 1'($urandom) : 1'b1;  // random write-back stalls
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pc(input string name, input logic [PC_W-1:0] got,
                          input logic [PC_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_wb(input logic en_got, input logic [REG_W-1:0] reg_got,
                          input mem_wb_t exp);
    checks++;
    if (en_got !== exp.wb_enable || reg_got !== exp.wb_reg)
    begin
      $display("Mismatch wb_enable/wb_reg: got %h/%h expected %h/%h",
               en_got, reg_got, exp.wb_enable, exp.wb_reg);
      errors++;
    end
  endtask

  // every output transfer is matched against the oldest accepted op
  always @(posedge clk)
  begin
    if (!reset && out_valid && out_ready)
    begin
      if (expected.size() == 0)
      begin
        $display("Output transfer seen with no operation outstanding");
        errors++;
      end
      else
      begin
        exp_res = expected.pop_front();
        check_data("read_data", read_data, exp_res.read_data);
        check_pc("final_pc", final_pc, exp_res.final_pc);
        check_wb(wb_enable, wb_reg, exp_res);
      end
    end
  end

  function automatic ex_mem_t base_op();
    ex_mem_t op;
    op             = '0;
    op.std_address = DATA_W'($urandom);
    op.ldd_address = DATA_W'($urandom);
    op.reg_data    = DATA_W'($urandom);
    op.flags       = FLAGS_W'($urandom);
    op.pc          = $urandom;
    op.pc_from_ex  = $urandom;
    op.wb_enable   = 1'($urandom);
    op.wb_reg      = REG_W'($urandom);
    return op;
  endfunction

  function automatic ex_mem_t access_op(input logic rd, input logic wr, input logic ps,
                                        input logic pp, input mem_addr_sel_t sel,
                                        input mem_wsrc_t src, input logic [ADDR_W-1:0] addr);
    ex_mem_t op;
    op          = base_op();
    op.read     = rd;
    op.write    = wr;
    op.push     = ps;
    op.pop      = pp;
    op.addr_sel = sel;
    op.wsrc     = src;
    if (sel == ADDR_LDD)
      op.ldd_address[ADDR_W-1:0] = addr;
    else
      op.std_address[ADDR_W-1:0] = addr;
    return op;
  endfunction

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_op(input ex_mem_t op);
    op_in    = op;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready)
      @(posedge clk);
    expected.push_back(ref_step(op));
    #1;
    in_valid = 1'b0;
  endtask

  task automatic reset_dut();
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_model();
  endtask

  task automatic end_test(input string name);
    while (expected.size() != 0)
      @(posedge clk);
    #1;
    tests_run++;
    if (errors == errors_at_start)
      $display("test %0d %s: pass", tests_run, name);
    else
    begin
      $display("test %0d %s: fail", tests_run, name);
      tests_failed++;
    end
    errors_at_start = errors;
  endtask

  initial
  begin
    ex_mem_t         op;
    logic [PC_W-1:0] ret_pc;
    int              kind;
    int              depth;
    void'($urandom(32'h8d5a5a5b));
    clk        = 1'b0;
    in_valid   = 1'b0;
    op_in      = '0;
    out_ready  = 1'b1;
    stall_mode = 1'b0;
    reset_dut();

    // register data lands in address 0 for the check after the second reset
    for (int k = 0; k < 4; k++)
    begin
      send_op(access_op(0, 1, 0, 0, ADDR_STD, mem_wsrc_t'(k), ADDR_W'(6 - 2 * k)));
      send_op(access_op(0, 1, 0, 0, ADDR_LDD, mem_wsrc_t'(k), ADDR_W'(7 - 2 * k)));
      send_op(access_op(1, 0, 0, 0, ADDR_STD, WSRC_REG, ADDR_W'(6 - 2 * k)));
      send_op(access_op(1, 0, 0, 0, ADDR_LDD, WSRC_REG, ADDR_W'(7 - 2 * k)));
    end
    end_test("store and load for every write source");

    send_op(access_op(0, 0, 1, 0, ADDR_STD, WSRC_REG, '0));
    send_op(access_op(1, 0, 0, 0, ADDR_STD, WSRC_REG, STACK_TOP));  // first push slot
    repeat (3) send_op(access_op(0, 0, 1, 0, ADDR_STD, WSRC_REG, '0));
    repeat (4) send_op(access_op(0, 0, 0, 1, ADDR_STD, WSRC_REG, '0));
    end_test("push and pop order");

    ret_pc = $urandom;
    op     = access_op(0, 0, 1, 0, ADDR_STD, WSRC_PC_HI, '0);
    op.pc  = ret_pc;
    send_op(op);
    op.wsrc = WSRC_PC_LO;
    send_op(op);
    repeat (2) send_op(access_op(0, 0, 0, 1, ADDR_STD, WSRC_REG, '0));
    op                = base_op();
    op.pc_from_memory = 1'b1;
    send_op(op);
    end_test("call and return through the stack");

    for (int i = 0; i < 8; i++)
    begin
      op                = access_op(i[2], 0, 0, 0, ADDR_STD, WSRC_REG, ADDR_W'(i));
      op.interrupt      = i[0];
      op.pc_from_memory = i[1];
      send_op(op);
    end
    end_test("interrupt vector and pc select");

    stall_mode = 1'b1;
    for (int a = 16; a < 32; a++)
      send_op(access_op(0, 1, 0, 0, ADDR_STD, WSRC_REG, ADDR_W'(a)));
    depth = 0;
    repeat (RANDOM_OPS)
    begin
      kind = $urandom % 5;  // none, load, store, push, pop
      if ((kind == 3 && depth >= 8) || (kind == 4 && depth == 0))
        kind = 1;
      depth += (kind == 3) - (kind == 4);
      op = access_op(kind == 1, kind == 2, kind == 3, kind == 4,
                     mem_addr_sel_t'(1'($urandom)), mem_wsrc_t'(2'($urandom)),
                     ADDR_W'(16 + $urandom % 16));
      op.interrupt      = ($urandom % 8) == 0;
      op.pc_from_memory = 1'($urandom);
      send_op(op);
    end
    end_test("random operations with back-pressure");
    stall_mode = 1'b0;

    reset_dut();
    if (out_valid !== 1'b0 || in_ready !== 1'b1)
    begin
      $display("Handshake outputs not idle after reset");
      errors++;
    end
    op                = base_op();
    op.pc_from_memory = 1'b1;  // return register cleared by reset
    send_op(op);
    send_op(access_op(0, 0, 0, 1, ADDR_STD, WSRC_REG, '0));  // wraps to address 0
    end_test("state after reset");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
